// File: keypadPkg.sv
// ====================================================================
// Shared types for the 4x4 keypad scanner
// ====================================================================
package keypadPkg;

    // Digit slots gathered into one frame
    localparam NUM_DIGITS = 4;

    // One hexadecimal key value from the legend
    typedef logic [3:0] keyDigit_t;

    // Column index, 0 is the leftmost column
    typedef logic [1:0] colIdx_t;

    // Active-low keypad lines
    // Line k sits in bit (3-k), so line 0 is the MSB
    typedef logic [3:0] lineVec_t;

    // ================================================================
    // Inter-block payloads
    // ================================================================

    // Row-sample instant from the column scanner
    typedef struct packed {
        logic    strobe;   // One-cycle pulse at the settling point
        colIdx_t colIdx;   // Column driven low at that instant
    } sampleStrobe_t;

    // Decoded key, one-cycle pulse
    typedef struct packed {
        logic      valid;
        keyDigit_t digit;
    } keyEvent_t;

    // Four digits in capture order
    // Slot 0 is the first digit captured
    typedef keyDigit_t [NUM_DIGITS-1:0] digitFrame_t;

    // ================================================================
    // Collector FSM
    // ================================================================

    // FILL takes keys into the slots
    // HOLD offers the finished frame and drops incoming keys
    typedef enum logic {
        COLLECT_FILL = 1'b0,
        COLLECT_HOLD = 1'b1
    } collectState_t;

endpackage

// File: columnScanner.sv
// ====================================================================
// Column scanner
// Drives one column low per slot and marks the row-sample point
// ====================================================================
module columnScanner
    import keypadPkg::*;
#(
    parameter int COLUMN_PERIOD = 100000,  // Cycles per column slot
    parameter int SETTLE_CYCLES = 8        // Column change to row sample
) (
    input  logic          clk,
    input  logic          i_reset,
    output lineVec_t      o_col,
    output sampleStrobe_t o_sample
);

    localparam int CNT_W = $clog2(COLUMN_PERIOD);

    localparam logic [CNT_W-1:0] LAST_CNT   = CNT_W'(COLUMN_PERIOD - 1);
    localparam logic [CNT_W-1:0] SAMPLE_CNT = CNT_W'(SETTLE_CYCLES);

    logic [CNT_W-1:0] periodCnt;
    colIdx_t          colIdx;
    lineVec_t         colReg;
    colIdx_t          nextCol;

    // Active-low one-hot pattern, line k in bit (3-k)
    function automatic lineVec_t colPattern(input colIdx_t col);
        lineVec_t pattern;
        pattern = ~(lineVec_t'(4'b1000) >> col);
        return pattern;
    endfunction

    assign nextCol = colIdx + 2'd1;  // Wraps 3 -> 0

    // ================================================================
    // Slot timer
    // ================================================================
    // Reset parks the counter at the end of column 3 so that the very
    // next cycle opens slot 0 with column 0 driven low
    always_ff @(posedge clk) begin
        if (i_reset) begin
            periodCnt <= LAST_CNT;
            colIdx    <= 2'd3;
            colReg    <= 4'b1111;  // All columns released
        end else if (periodCnt == LAST_CNT) begin
            periodCnt <= '0;
            colIdx    <= nextCol;
            colReg    <= colPattern(nextCol);
        end else begin
            periodCnt <= periodCnt + 1'b1;
        end
    end

    assign o_col = colReg;

    // Sample strobe, rows have had SETTLE_CYCLES to follow the column
    assign o_sample.strobe = (periodCnt == SAMPLE_CNT);
    assign o_sample.colIdx = colIdx;

endmodule

// File: keyDecoder.sv
// ====================================================================
// Key decoder
// Checks the row sample and maps (row, column) onto the legend
// ====================================================================
module keyDecoder
    import keypadPkg::*;
(
    input  logic          clk,
    input  logic          i_reset,
    input  sampleStrobe_t i_sample,
    input  lineVec_t      i_row,
    output keyEvent_t     o_key
);

    // Legend indexed [column][row]
    localparam keyDigit_t LEGEND [4][4] = '{
        '{4'h1, 4'h4, 4'h7, 4'h0},  // Column 0
        '{4'h2, 4'h5, 4'h8, 4'hF},  // Column 1
        '{4'h3, 4'h6, 4'h9, 4'hE},  // Column 2
        '{4'hA, 4'hB, 4'hC, 4'hD}   // Column 3
    };

    logic       oneRowLow;
    logic [1:0] rowIdx;
    logic       keyValid;
    keyDigit_t  keyDigit;

    // ================================================================
    // Row check
    // ================================================================
    // Only a single low row is a key; none or several is rejected
    always_comb begin
        oneRowLow = 1'b1;
        rowIdx    = 2'd0;
        case (i_row)
            4'b0111: rowIdx = 2'd0;
            4'b1011: rowIdx = 2'd1;
            4'b1101: rowIdx = 2'd2;
            4'b1110: rowIdx = 2'd3;
            default: oneRowLow = 1'b0;
        endcase
    end

    // ================================================================
    // Event register
    // ================================================================
    always_ff @(posedge clk) begin
        if (i_reset) begin
            keyValid <= 1'b0;
        end else begin
            keyValid <= i_sample.strobe & oneRowLow;
        end
    end

    // Digit payload, only meaningful alongside keyValid
    always_ff @(posedge clk) begin
        if (i_sample.strobe) begin
            keyDigit <= LEGEND[i_sample.colIdx][rowIdx];
        end
    end

    assign o_key.valid = keyValid;
    assign o_key.digit = keyDigit;

endmodule

// File: digitCollector.sv
// ====================================================================
// Digit collector
// Fills the frame slots in order and offers the full frame
// ====================================================================
module digitCollector
    import keypadPkg::*;
(
    input  logic        clk,
    input  logic        i_reset,
    input  keyEvent_t   i_key,
    input  logic        i_busy,
    output digitFrame_t o_frame,
    output logic        o_valid
);

    localparam int PTR_W = $clog2(NUM_DIGITS);

    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(NUM_DIGITS - 1);

    collectState_t    state;
    logic [PTR_W-1:0] slotPtr;
    digitFrame_t      frameReg;
    logic             keyTaken;
    logic             transfer;

    // Keys only count while filling
    assign keyTaken = (state == COLLECT_FILL) && i_key.valid;

    // Transmitter takes the frame in the first non-busy cycle
    assign transfer = (state == COLLECT_HOLD) && !i_busy;

    // ================================================================
    // Control FSM
    // ================================================================
    always_ff @(posedge clk) begin
        if (i_reset) begin
            state   <= COLLECT_FILL;
            slotPtr <= '0;
        end else begin
            case (state)
                COLLECT_FILL: begin
                    if (keyTaken) begin
                        if (slotPtr == LAST_SLOT) begin
                            state   <= COLLECT_HOLD;  // Frame complete
                            slotPtr <= '0;
                        end else begin
                            slotPtr <= slotPtr + 1'b1;
                        end
                    end
                end
                COLLECT_HOLD: begin
                    // Incoming keys are dropped here
                    if (transfer) begin
                        state   <= COLLECT_FILL;
                        slotPtr <= '0;
                    end
                end
                default: begin
                    state   <= COLLECT_FILL;
                    slotPtr <= '0;
                end
            endcase
        end
    end

    // ================================================================
    // Frame slots
    // ================================================================
    // Slots are written only in FILL, so the frame stays frozen in HOLD
    always_ff @(posedge clk) begin
        if (keyTaken) begin
            frameReg[slotPtr] <= i_key.digit;
        end
    end

    assign o_frame = frameReg;
    assign o_valid = (state == COLLECT_HOLD);  // Held until transfer

endmodule

// File: keypadTop.sv
// ====================================================================
// Keypad scanner top level
// Column scan -> key decode -> frame collection
// ====================================================================
module keypadTop
    import keypadPkg::*;
#(
    parameter int COLUMN_PERIOD = 100000,
    parameter int SETTLE_CYCLES = 8
) (
    input  logic        clk,
    input  logic        i_reset,
    input  lineVec_t    i_row,   // Keypad rows, active low
    input  logic        i_busy,  // Transmitter back-pressure
    output lineVec_t    o_col,   // Keypad columns, active low
    output digitFrame_t o_frame,
    output logic        o_valid
);

    sampleStrobe_t sample;
    keyEvent_t     keyEvent;

    // ================================================================
    // Column timing
    // ================================================================
    columnScanner #(
        .COLUMN_PERIOD (COLUMN_PERIOD),
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) uScanner (
        .clk      (clk),
        .i_reset  (i_reset),
        .o_col    (o_col),
        .o_sample (sample)
    );

    // ================================================================
    // Row decode
    // ================================================================
    keyDecoder uDecoder (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_sample (sample),
        .i_row    (i_row),
        .o_key    (keyEvent)
    );

    // ================================================================
    // Frame assembly and handshake
    // ================================================================
    digitCollector uCollector (
        .clk     (clk),
        .i_reset (i_reset),
        .i_key   (keyEvent),
        .i_busy  (i_busy),
        .o_frame (o_frame),
        .o_valid (o_valid)
    );

endmodule

// File: tbKeypad.sv
module tbKeypad
    import keypadPkg::*;
();

    localparam int COLUMN_PERIOD  = 16;
    localparam int SETTLE_CYCLES  = 4;
    localparam int SCAN_CYCLES    = 4 * COLUMN_PERIOD;
    localparam int TIMEOUT_CYCLES = 400 * SCAN_CYCLES;
    localparam int RESET_CYCLES   = 8;
    localparam int DRIVE_DELAY    = 2;
    localparam int MAX_FRAMES     = 32;

    localparam lineVec_t COL0_LOW = 4'b0111;

    // Physical keypad face indexed [row][column]
    localparam keyDigit_t KEY_LAYOUT [4][4] = '{
        '{4'h1, 4'h2, 4'h3, 4'hA},
        '{4'h4, 4'h5, 4'h6, 4'hB},
        '{4'h7, 4'h8, 4'h9, 4'hC},
        '{4'h0, 4'hF, 4'hE, 4'hD}
    };

    logic        clk;
    logic        i_reset;
    lineVec_t    i_row;
    logic        i_busy;
    lineVec_t    o_col;
    digitFrame_t o_frame;
    logic        o_valid;

    logic [15:0] pressedKeys = '0;  // Bit row*4+col
    int unsigned cyclesSinceReset;
    int unsigned cycleCount = 0;
    digitFrame_t prevFrame;

    // Expected-frame model
    digitFrame_t expFrames [MAX_FRAMES];
    digitFrame_t curFrame;
    int          curCount = 0;
    int          framesCompleted = 0;
    int          acceptCount = 0;
    int          discardCount = 0;

    logic        randomBusy = 1'b0;
    int unsigned nextStretch = 0;

    int    errorCount = 0;
    int    testErrorBase;
    int    testsPassed = 0;
    int    testsFailed = 0;
    string testName;

    keypadTop #(
        .COLUMN_PERIOD (COLUMN_PERIOD),
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) DUT (
        .clk     (clk),
        .i_reset (i_reset),
        .i_row   (i_row),
        .i_busy  (i_busy),
        .o_col   (o_col),
        .o_frame (o_frame),
        .o_valid (o_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ================================================================
    // Keypad matrix model
    // ================================================================
    // Row r pulled low through any pressed key on a low column
    always_comb begin
        i_row = 4'b1111;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (pressedKeys[r * 4 + c] && (o_col[3 - c] == 1'b0)) begin
                    i_row[3 - r] = 1'b0;
                end
            end
        end
    end

    // Column expected after a given number of cycles out of reset
    function automatic lineVec_t expectedCol(input int unsigned cyclesRun);
        lineVec_t pattern;
        if (cyclesRun == 0) begin
            pattern = 4'b1111;  // Scan not started yet
        end else begin
            case (((cyclesRun - 1) / COLUMN_PERIOD) % 4)
                0:       pattern = 4'b0111;
                1:       pattern = 4'b1011;
                2:       pattern = 4'b1101;
                default: pattern = 4'b1110;
            endcase
        end
        return pattern;
    endfunction

    always @(posedge clk) begin
        if (i_reset) begin
            cyclesSinceReset <= 0;
            acceptCount      <= 0;
        end else begin
            cyclesSinceReset <= cyclesSinceReset + 1;
            if (o_valid && !i_busy) begin
                acceptCount <= acceptCount + 1;  // Transmitter took a frame
            end
        end
        prevFrame <= o_frame;
    end

    // Run limit
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // ================================================================
    // Checks
    // ================================================================
    colOneLow: assert property (@(posedge clk) disable iff (i_reset)
            $countones(~o_col) <= 1)
        else begin
            $display("Fail at %0t: o_col expected at most one low bit, got %b",
                $time, $sampled(o_col));
            errorCount++;
        end

    colSequence: assert property (@(posedge clk) disable iff (i_reset)
            o_col == expectedCol(cyclesSinceReset))
        else begin
            $display("Fail at %0t: o_col expected %b, got %b", $time,
                expectedCol($sampled(cyclesSinceReset)), $sampled(o_col));
            errorCount++;
        end

    validWithFrame: assert property (@(posedge clk) disable iff (i_reset)
            o_valid |-> (framesCompleted > acceptCount))
        else begin
            $display("Error at %0t: o_valid is high but no complete frame was pressed", $time);
            errorCount++;
        end

    frameMatch: assert property (@(posedge clk) disable iff (i_reset)
            (o_valid && !i_busy) |-> (o_frame == expFrames[acceptCount]))
        else begin
            $display("Fail at %0t: o_frame expected %h, got %h", $time,
                expFrames[$sampled(acceptCount)], $sampled(o_frame));
            errorCount++;
        end

    validHeld: assert property (@(posedge clk) disable iff (i_reset)
            (o_valid && i_busy) |=> o_valid)
        else begin
            $display("Error at %0t: o_valid dropped while i_busy was high", $time);
            errorCount++;
        end

    frameHeld: assert property (@(posedge clk) disable iff (i_reset)
            (o_valid && i_busy) |=> (o_frame == prevFrame))
        else begin
            $display("Fail at %0t: o_frame expected %h, got %h", $time,
                $sampled(prevFrame), $sampled(o_frame));
            errorCount++;
        end

    validDrops: assert property (@(posedge clk) disable iff (i_reset)
            (o_valid && !i_busy) |=> !o_valid)
        else begin
            $display("Error at %0t: o_valid still high after the frame was accepted", $time);
            errorCount++;
        end

    // Random back-pressure raised only once a frame is offered
    initial begin
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (randomBusy && o_valid) begin
                if (nextStretch != 0) begin
                    i_busy = 1'b1;
                    repeat (nextStretch) @(posedge clk);
                    #DRIVE_DELAY;
                    i_busy = 1'b0;
                end
                while (o_valid) begin
                    @(posedge clk);
                    #DRIVE_DELAY;
                end
            end
        end
    end

    // ================================================================
    // Stimulus tasks
    // ================================================================
    task automatic waitCycles(input int count);
        repeat (count) @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // Wait until column 0 has just been driven low
    task automatic waitScanStart();
        while (o_col == COL0_LOW) begin
            waitCycles(1);
        end
        while (o_col != COL0_LOW) begin
            waitCycles(1);
        end
    endtask

    // Hold a key set for one full scan from the current column 0 slot
    task automatic holdScan(input logic [15:0] keyMask);
        pressedKeys = keyMask;
        waitCycles(SCAN_CYCLES);
        pressedKeys = '0;
    endtask

    // Hold a key set for one full scan starting at a fresh column 0
    task automatic holdKeys(input logic [15:0] keyMask);
        waitScanStart();
        holdScan(keyMask);
    endtask

    task automatic pressKey(input int row, input int col);
        waitScanStart();
        if (framesCompleted > acceptCount) begin
            discardCount++;  // Key lost while the frame is held
        end else begin
            curFrame[curCount] = KEY_LAYOUT[row][col];
            curCount++;
            if (curCount == NUM_DIGITS) begin
                expFrames[framesCompleted] = curFrame;
                framesCompleted++;
                curCount = 0;
            end
        end
        holdScan(16'b1 << (row * 4 + col));
    endtask

    task automatic waitAllAccepted();
        while (acceptCount != framesCompleted) begin
            waitCycles(1);
        end
    endtask

    task automatic startTest(input string name);
        testName      = name;
        testErrorBase = errorCount;
    endtask

    task automatic endTest();
        if (errorCount == testErrorBase) begin
            $display("Pass: %s", testName);
            testsPassed++;
        end else begin
            $display("Fail: %s, %0d check(s) failed", testName, errorCount - testErrorBase);
            testsFailed++;
        end
    endtask

    // ================================================================
    // Test sequence
    // ================================================================
    initial begin
        void'($urandom(32'h782c_bbe2));
        i_reset = 1'b1;
        i_busy  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        i_reset = 1'b0;

        startTest("column scan");
        waitCycles(5 * SCAN_CYCLES);
        endTest();

        startTest("key legend");
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                pressKey(r, c);
            end
        end
        waitAllAccepted();
        endTest();

        startTest("invalid samples");
        waitCycles(2 * SCAN_CYCLES);   // Idle scans
        holdKeys(16'h0202);            // Rows 0 and 2 on column 1
        holdKeys(16'h8008);            // Rows 0 and 3 on column 3
        pressKey(3, 2);
        pressKey(0, 0);
        pressKey(2, 3);
        pressKey(1, 1);
        waitAllAccepted();
        endTest();

        startTest("back-pressure");
        i_busy = 1'b1;
        pressKey(0, 0);
        pressKey(1, 1);
        pressKey(2, 2);
        pressKey(3, 3);
        pressKey(0, 3);  // Dropped, frame held
        pressKey(3, 0);
        waitCycles(20);
        i_busy = 1'b0;
        waitAllAccepted();
        pressKey(2, 0);
        pressKey(1, 2);
        pressKey(3, 1);
        pressKey(0, 2);
        waitAllAccepted();
        endTest();

        startTest("random frames");
        randomBusy = 1'b1;
        for (int f = 0; f < 8; f++) begin
            nextStretch = $urandom_range(40, 0);
            for (int k = 0; k < NUM_DIGITS; k++) begin
                pressKey($urandom_range(3, 0), $urandom_range(3, 0));
            end
        end
        waitAllAccepted();
        randomBusy = 1'b0;
        endTest();

        $display("Tests: %0d passed, %0d failed, %0d check errors, %0d keys dropped",
            testsPassed, testsFailed, errorCount, discardCount);
        if (errorCount == 0 && testsFailed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: compile.f
keypadPkg.sv
columnScanner.sv
keyDecoder.sv
digitCollector.sv
keypadTop.sv
tbKeypad.sv

// File: Bender.yml
package:
  name: keypad_scanner

dependencies: {}

sources:
  # Package first, then the blocks, then the top level
  - keypadPkg.sv
  - columnScanner.sv
  - keyDecoder.sv
  - digitCollector.sv
  - keypadTop.sv

  # Testbench
  - target: test
    files:
      - tbKeypad.sv
